// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = m68kCacheTb
FILELIST = m68kCache.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/m68kCacheTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "m68kCache_cfg.svh"

module m68kCacheTb;

	localparam int TIMEOUT = 200;                     // cycles per wait

	logic Clock;
	logic Reset_L;
	m68kCachePkg::cpuReqT cpuReq;
	m68kCachePkg::dramRspT dramRsp;
	m68kCachePkg::wordT cpuReadData;
	logic dtackL;
	m68kCachePkg::dramReqT dramReq;

	int errorCount = 0;
	int timeoutCount = 0;

	// reference model state
	bit modelValid [`CACHE_SETS][`CACHE_WAYS];
	m68kCachePkg::tagT modelTag [`CACHE_SETS][`CACHE_WAYS];
	m68kCachePkg::lruT modelLru [`CACHE_SETS];
	m68kCachePkg::wordT dramMem [m68kCachePkg::addrT];  // written words only

	tbClock clockGen (.Clock, .Reset_L);

	m68kCache DUT (
		.Clock, .Reset_L, .cpuReq, .dramRsp, .cpuReadData, .dtackL, .dramReq
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic endRun();
		$display("errors: %0d compare, %0d timeout", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	task automatic timedOut(input string what);
		timeoutCount++;
		$display("timeout at %0t while waiting for %s", $time, what);
		endRun();
	endtask

	task automatic compareWord(input m68kCachePkg::wordT got, input m68kCachePkg::wordT exp,
			input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compareAddr(input m68kCachePkg::addrT got, input m68kCachePkg::addrT exp,
			input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compareHit(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// DRAM contents, an address hash where nothing was written
	function automatic m68kCachePkg::wordT memRead(input m68kCachePkg::addrT a);
		m68kCachePkg::addrT key;
		logic [31:0] h;
		key = {a[31:1], 1'b0};
		if (dramMem.exists(key)) return dramMem[key];
		h = key * 32'h9E3779B1;
		return h[31:16] ^ key[15:0];
	endfunction

	function automatic m68kCachePkg::wayT lruVictim(input m68kCachePkg::lruT b);
		if (!b[0]) return b[1] ? 2'd1 : 2'd0;
		return b[2] ? 2'd3 : 2'd2;
	endfunction

	function automatic m68kCachePkg::lruT lruUpdate(input m68kCachePkg::lruT b,
			input m68kCachePkg::wayT w);
		m68kCachePkg::lruT n;
		n = b;
		n[0] = (w <= 2'd1);
		case (w)
			2'd0: n[1] = 1'b1;
			2'd1: n[1] = 1'b0;
			2'd2: n[2] = 1'b1;
			default: n[2] = 1'b0;
		endcase
		return n;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// DRAM model
	////////////////////////////////////////////////////////////////////////////

	task automatic waitDeselect();
		int n;
		n = 0;
		do begin
			@(negedge Clock);
			if (++n > TIMEOUT) timedOut("DRAM select release");
		end while (!dramReq.selectL);
	endtask

	initial begin
		m68kCachePkg::addrT lineAddr;
		m68kCachePkg::addrT key;
		forever begin
			@(negedge Clock);
			if (Reset_L && !dramReq.selectL) begin
				lineAddr = dramReq.addr;
				repeat (1 + $urandom % 4) @(posedge Clock);
				if (dramReq.weL) begin
					if ($urandom % 3 == 0) begin         // refresh before the CAS
						@(posedge Clock);
						dramRsp.casL <= 1'b0;
						dramRsp.rasL <= 1'b0;
						@(posedge Clock);
						dramRsp.casL <= 1'b1;
						dramRsp.rasL <= 1'b1;
					end
					@(posedge Clock);
					dramRsp.casL <= 1'b0;                // cycle c
					@(posedge Clock);
					dramRsp.casL <= 1'b1;
					@(posedge Clock);
					for (int k = 0; k < `BURST_LEN; k++) begin
						@(posedge Clock);                // cycles c+3 .. c+10
						dramRsp.readData <= memRead(lineAddr + 32'(2 * k));
					end
					waitDeselect();
				end else begin
					@(posedge Clock);
					key = {lineAddr[31:1], 1'b0};
					dramMem[key] = memRead(key);
					if (!dramReq.udsL) dramMem[key][15:8] = dramReq.writeData[15:8];
					if (!dramReq.ldsL) dramMem[key][7:0] = dramReq.writeData[7:0];
					dramRsp.dtackL <= 1'b0;
					waitDeselect();
					@(posedge Clock);
					dramRsp.dtackL <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// CPU side
	////////////////////////////////////////////////////////////////////////////

	task automatic releaseBus();
		int n;
		@(posedge Clock);
		cpuReq.asL <= 1'b1;
		n = 0;
		do begin
			@(negedge Clock);
			if (++n > TIMEOUT) timedOut("dtackL release");
		end while (!dtackL);
		repeat (2) @(posedge Clock);
	endtask

	task automatic cpuRead(input m68kCachePkg::addrT a);
		m68kCachePkg::indexT set;
		m68kCachePkg::tagT tag;
		m68kCachePkg::wayT way;
		bit hit;
		bit sawSelect;
		int n;
		set = a[`TAG_LSB-1:`INDEX_LSB];
		tag = a[31:`TAG_LSB];
		hit = 0;
		way = lruVictim(modelLru[set]);
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelValid[set][w] && modelTag[set][w] == tag) begin
				hit = 1;
				way = 2'(w);
			end
		end
		@(posedge Clock);
		cpuReq <= '{addr: a, writeData: '0, udsL: 1'b0, ldsL: 1'b0, weL: 1'b1,
			asL: 1'b0, dramSelect: 1'b1};
		sawSelect = 0;
		n = 0;
		do begin
			@(negedge Clock);
			if (!dramReq.selectL && !sawSelect) begin
				sawSelect = 1;
				compareAddr(dramReq.addr, {a[31:4], 4'h0}, "fill address");
				compareHit(dramReq.weL, 1'b1, "fill weL");
			end
			if (++n > TIMEOUT) timedOut("read dtackL");
		end while (dtackL);
		compareWord(cpuReadData, memRead(a), "read data");
		compareHit(!sawSelect, hit, "read hit");
		modelValid[set][way] = 1;
		modelTag[set][way] = tag;
		modelLru[set] = lruUpdate(modelLru[set], way);
		releaseBus();
	endtask

	task automatic cpuWrite(input m68kCachePkg::addrT a, input m68kCachePkg::wordT d,
			input logic [1:0] strobes);
		m68kCachePkg::indexT set;
		bit sawSelect;
		int n;
		set = a[`TAG_LSB-1:`INDEX_LSB];
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelTag[set][w] == a[31:`TAG_LSB]) modelValid[set][w] = 0;
		end
		@(posedge Clock);
		cpuReq <= '{addr: a, writeData: d, udsL: strobes[1], ldsL: strobes[0], weL: 1'b0,
			asL: 1'b0, dramSelect: 1'b1};
		sawSelect = 0;
		n = 0;
		do begin
			@(negedge Clock);
			if (!dramReq.selectL && !sawSelect) begin
				sawSelect = 1;
				compareAddr(dramReq.addr, a, "write address");
				compareWord(dramReq.writeData, d, "write data");
				compareHit(dramReq.udsL, strobes[1], "write udsL");
				compareHit(dramReq.ldsL, strobes[0], "write ldsL");
				compareHit(dramReq.weL, 1'b0, "write weL");
				compareHit(dramReq.asL, 1'b0, "write asL");
			end
			compareHit(dtackL, dramRsp.dtackL, "write dtackL");
			if (++n > TIMEOUT) timedOut("write dtackL");
		end while (dtackL);
		releaseBus();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		m68kCachePkg::addrT a;
		logic [1:0] strobes;
		int n;
		void'($urandom(63457));
		cpuReq = '{addr: '0, writeData: '0, udsL: 1'b1, ldsL: 1'b1, weL: 1'b1,
			asL: 1'b1, dramSelect: 1'b0};
		dramRsp = '{readData: '0, dtackL: 1'b1, casL: 1'b1, rasL: 1'b1};
		for (int s = 0; s < `CACHE_SETS; s++) begin
			modelLru[s] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				modelValid[s][w] = 0;
				modelTag[s][w] = '0;
			end
		end
		n = 0;
		do begin
			@(posedge Clock);
			if (++n > 100) timedOut("reset release");
		end while (!Reset_L);
		repeat (12) @(posedge Clock);             // Reset plus the 8 set walk

		// six tags per set so the fifth and sixth force evictions
		for (int i = 0; i < 400; i++) begin
			a = {25'h0_1234 + 25'(($urandom % 6) * 25'h101), 3'($urandom % 8),
				3'($urandom % 8), 1'b0};
			if ($urandom % 5 == 0) begin
				case ($urandom % 3)
					0: strobes = 2'b00;
					1: strobes = 2'b01;
					default: strobes = 2'b10;
				endcase
				cpuWrite(a, 16'($urandom), strobes);
			end else begin
				cpuRead(a);
			end
		end
		endRun();
	end

endmodule

`default_nettype wire

// File: dv/m68kCache_chk.sv
`timescale 1ns/1ns
`default_nettype none

module m68kCache_chk (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire m68kCachePkg::dramReqT dramReq,
	input wire logic dtackL,
	input wire m68kCachePkg::wayMaskT wayHit
);

	// both strobes idle while reset is held
	resetIdle: assert property (@(posedge Clock) !Reset_L |-> (dramReq.selectL && dtackL))
		else $error("selectL or dtackL low during reset");

	// a line lives in one way only
	oneHit: assert property (@(posedge Clock) disable iff (!Reset_L) $onehot0(wayHit))
		else $error("more than one way hits");

	// fills are line aligned, writes carry the full address
	fillAligned: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!dramReq.selectL && dramReq.weL) |-> (dramReq.addr[3:0] == 4'h0))
		else $error("fill address not line aligned");

endmodule

bind m68kCache m68kCache_chk chk (
	.Clock, .Reset_L, .dramReq, .dtackL, .wayHit
);

`default_nettype wire

// File: dv/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
	output logic Clock,
	output logic Reset_L
);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;                // 10 ns period
	end

	// reset held for 16 cycles, released away from the rising edge
	initial begin
		Reset_L = 1'b0;
		repeat (16) @(posedge Clock);
		@(negedge Clock);
		Reset_L = 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/m68kCache.sv
`timescale 1ns/1ns
`default_nettype none

`include "m68kCache_cfg.svh"

module m68kCache (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire m68kCachePkg::cpuReqT cpuReq,
	input wire m68kCachePkg::dramRspT dramRsp,
	output m68kCachePkg::wordT cpuReadData,
	output logic dtackL,
	output m68kCachePkg::dramReqT dramReq
);

	m68kCachePkg::indexT index;
	m68kCachePkg::tagT cpuTag;
	m68kCachePkg::wayMaskT wayHit;
	m68kCachePkg::wayMaskT tagWriteMask;
	logic tagWriteValid;
	m68kCachePkg::wordSelT dataWriteWord;
	logic dataWriteEnable;
	m68kCachePkg::wayT dataWay;
	m68kCachePkg::wordSelT readWord;
	logic lruAccess;
	m68kCachePkg::wayT accessWay;
	logic lruClear;
	m68kCachePkg::wayT victim;

	assign cpuTag = cpuReq.addr[31:`TAG_LSB];     // lookup and fill use the same tag

	m68kCacheController controller (
		.Clock, .Reset_L, .cpuReq, .dramRsp, .wayHit, .victim, .dramReq, .dtackL,
		.index, .tagWriteMask, .tagWriteValid, .dataWriteWord, .dataWriteEnable,
		.dataWay, .readWord, .lruAccess, .accessWay, .lruClear
	);

	m68kCacheTagStore tagStore (
		.Clock, .Reset_L, .index, .lookupTag(cpuTag), .writeMask(tagWriteMask),
		.writeTag(cpuTag), .writeValid(tagWriteValid), .wayHit
	);

	// burst words go straight from the DRAM bus into the line
	m68kCacheDataStore dataStore (
		.Clock, .index, .writeWord(dataWriteWord), .writeData(dramRsp.readData),
		.writeEnable(dataWriteEnable), .way(dataWay), .readWord, .readData(cpuReadData)
	);

	m68kCacheLruStore lruStore (
		.Clock, .Reset_L, .index, .lruAccess, .accessWay, .lruClear, .victim
	);

endmodule

`default_nettype wire

// File: hdl/m68kCacheController.sv
`timescale 1ns/1ns
`default_nettype none

`include "m68kCache_cfg.svh"

module m68kCacheController (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire m68kCachePkg::cpuReqT cpuReq,
	input wire m68kCachePkg::dramRspT dramRsp,
	input wire m68kCachePkg::wayMaskT wayHit,
	input wire m68kCachePkg::wayT victim,
	output m68kCachePkg::dramReqT dramReq,
	output logic dtackL,                          // to the CPU
	output m68kCachePkg::indexT index,
	output m68kCachePkg::wayMaskT tagWriteMask,
	output logic tagWriteValid,
	output m68kCachePkg::wordSelT dataWriteWord,
	output logic dataWriteEnable,
	output m68kCachePkg::wayT dataWay,
	output m68kCachePkg::wordSelT readWord,
	output logic lruAccess,
	output m68kCachePkg::wayT accessWay,
	output logic lruClear
);

	m68kCachePkg::cacheStateT state;
	m68kCachePkg::cacheStateT nextState;
	logic [3:0] burstCount;                       // set walk, then fill words
	logic burstClear;
	m68kCachePkg::wayT wayReg;                    // way being filled or read back
	m68kCachePkg::wayT hitWay;

	assign readWord = cpuReq.addr[`INDEX_LSB-1:`WORD_LSB];

	// one hot hit vector to way number
	always_comb begin
		hitWay = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (wayHit[w]) begin
				hitWay = m68kCachePkg::wayT'(w);
			end
		end
	end

	// hit way on a hit, else the victim; a fill counts as an access too
	assign accessWay = (|wayHit) ? hitWay : victim;
	assign lruAccess = (state == m68kCachePkg::CheckHit);
	// wayReg is not loaded yet in CheckHit
	assign dataWay = (state == m68kCachePkg::CheckHit) ? accessWay : wayReg;

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= m68kCachePkg::Reset;
			burstCount <= '0;
		end else begin
			state <= nextState;
			burstCount <= burstClear ? 4'd0 : burstCount + 4'd1; // free running
		end
	end

	always_ff @(posedge Clock) begin
		if (state == m68kCachePkg::CheckHit) begin
			wayReg <= accessWay;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		dramReq.addr = cpuReq.addr;
		dramReq.addr[`INDEX_LSB-1:0] = '0;                    // line aligned for fills
		dramReq.writeData = cpuReq.writeData;
		dramReq.udsL = cpuReq.udsL;
		dramReq.ldsL = cpuReq.ldsL;
		dramReq.weL = cpuReq.weL;
		dramReq.asL = cpuReq.asL;
		dramReq.selectL = 1'b1;                               // DRAM left alone
		dtackL = 1'b1;
		index = cpuReq.addr[`TAG_LSB-1:`INDEX_LSB];
		tagWriteMask = '0;
		tagWriteValid = 1'b0;
		dataWriteWord = burstCount[$bits(m68kCachePkg::wordSelT)-1:0];
		dataWriteEnable = 1'b0;
		lruClear = 1'b0;
		burstClear = 1'b0;

		// both bytes are fetched on every read, whatever the CPU strobes say
		if (state inside {m68kCachePkg::CheckHit, m68kCachePkg::WaitCacheRead,
				m68kCachePkg::ReadFill, m68kCachePkg::CasDelay1, m68kCachePkg::CasDelay2,
				m68kCachePkg::BurstFill, m68kCachePkg::EndFill}) begin
			dramReq.udsL = 1'b0;
			dramReq.ldsL = 1'b0;
		end

		unique case (state)
			m68kCachePkg::Reset: begin
				burstClear = 1'b1;                                // walk starts at set 0
				nextState = m68kCachePkg::Invalidate;
			end
			m68kCachePkg::Invalidate: begin
				index = burstCount[$bits(m68kCachePkg::indexT)-1:0];
				tagWriteMask = '1;                                // all ways invalid
				lruClear = 1'b1;
				if (burstCount == `CACHE_SETS - 1) nextState = m68kCachePkg::Idle;
			end
			m68kCachePkg::Idle: begin
				dramReq.addr = cpuReq.addr;                       // a write goes out whole
				if (!cpuReq.asL && cpuReq.dramSelect) begin
					if (cpuReq.weL) begin
						nextState = m68kCachePkg::CheckHit;
					end else begin
						dramReq.selectL = 1'b0;                   // start the write early
						tagWriteMask = wayHit;                    // drop any stale copy
						nextState = m68kCachePkg::WriteDram;
					end
				end
			end
			m68kCachePkg::CheckHit: begin
				if (|wayHit) begin
					dtackL = 1'b0;                                // word already on readData
					nextState = m68kCachePkg::WaitCacheRead;
				end else begin
					nextState = m68kCachePkg::ReadFill;
				end
			end
			m68kCachePkg::WaitCacheRead: begin
				dtackL = 1'b0;
				if (cpuReq.asL) nextState = m68kCachePkg::Idle;
			end
			m68kCachePkg::ReadFill: begin
				dramReq.selectL = 1'b0;
				tagWriteMask = m68kCachePkg::wayMaskT'(1) << wayReg; // claim the line
				tagWriteValid = 1'b1;
				// CAS with RAS also low is a refresh, keep waiting
				if (!dramRsp.casL && dramRsp.rasL) nextState = m68kCachePkg::CasDelay1;
			end
			m68kCachePkg::CasDelay1: begin
				dramReq.selectL = 1'b0;
				nextState = m68kCachePkg::CasDelay2;
			end
			m68kCachePkg::CasDelay2: begin
				dramReq.selectL = 1'b0;
				burstClear = 1'b1;                                // first word next cycle
				nextState = m68kCachePkg::BurstFill;
			end
			m68kCachePkg::BurstFill: begin
				dramReq.selectL = 1'b0;
				dataWriteEnable = 1'b1;                           // one word per clock
				if (burstCount == `BURST_LEN - 1) nextState = m68kCachePkg::EndFill;
			end
			m68kCachePkg::EndFill: begin
				dtackL = 1'b0;                                    // read back from wayReg
				if (cpuReq.asL || !cpuReq.dramSelect) nextState = m68kCachePkg::Idle;
			end
			m68kCachePkg::WriteDram: begin
				dramReq.addr = cpuReq.addr;
				dramReq.selectL = 1'b0;
				dtackL = dramRsp.dtackL;                          // DRAM paces the write
				if (cpuReq.asL || !cpuReq.dramSelect) nextState = m68kCachePkg::Idle;
			end
			default: begin
				nextState = m68kCachePkg::Reset;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/m68kCacheDataStore.sv
`timescale 1ns/1ns
`default_nettype none

`include "m68kCache_cfg.svh"

module m68kCacheDataStore (
	input wire logic Clock,
	input wire m68kCachePkg::indexT index,
	input wire m68kCachePkg::wordSelT writeWord,   // burst position
	input wire m68kCachePkg::wordT writeData,      // straight from DRAM
	input wire logic writeEnable,
	input wire m68kCachePkg::wayT way,             // way for both write and read
	input wire m68kCachePkg::wordSelT readWord,    // CPU word select
	output m68kCachePkg::wordT readData
);

	// line data, one word per way, set and word position
	m68kCachePkg::wordT lineData [`CACHE_WAYS][`CACHE_SETS][`LINE_WORDS];

	// one burst word per clock during the fill
	always_ff @(posedge Clock) begin
		if (writeEnable) begin
			lineData[way][index][writeWord] <= writeData;
		end
	end

	// asynchronous read so the word is there in the same cycle as dtack
	assign readData = lineData[way][index][readWord];

endmodule

`default_nettype wire

// File: hdl/m68kCacheLruStore.sv
`timescale 1ns/1ns
`default_nettype none

`include "m68kCache_cfg.svh"

module m68kCacheLruStore (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire m68kCachePkg::indexT index,
	input wire logic lruAccess,                   // one cycle pulse per access
	input wire m68kCachePkg::wayT accessWay,
	input wire logic lruClear,                    // used while invalidating
	output m68kCachePkg::wayT victim
);

	m68kCachePkg::lruT lruBits [`CACHE_SETS];     // tree bits per set
	m68kCachePkg::lruT curBits;
	m68kCachePkg::lruT nextBits;

	assign curBits = lruBits[index];

	// bit0 picks the half, bit1 or bit2 picks the way inside it
	always_comb begin
		if (!curBits[0]) begin
			victim = curBits[1] ? m68kCachePkg::wayT'(1) : m68kCachePkg::wayT'(0);
		end else begin
			victim = curBits[2] ? m68kCachePkg::wayT'(3) : m68kCachePkg::wayT'(2);
		end
	end

	// tree update for the accessed way, the other subtree is untouched
	always_comb begin
		nextBits = curBits;
		nextBits[0] = (accessWay < m68kCachePkg::wayT'(2));  // ways 0 and 1 set it
		if (accessWay[1]) begin
			nextBits[2] = !accessWay[0];                        // way2 sets, way3 clears
		end else begin
			nextBits[1] = !accessWay[0];                        // way0 sets, way1 clears
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				lruBits[s] <= '0;
			end
		end else if (lruClear) begin
			lruBits[index] <= '0;
		end else if (lruAccess) begin
			lruBits[index] <= nextBits;
		end
	end

endmodule

`default_nettype wire

// File: hdl/m68kCachePkg.sv
`default_nettype none

`include "m68kCache_cfg.svh"

package m68kCachePkg;

	typedef logic [15:0] wordT;                                // one data bus word
	typedef logic [31:0] addrT;                                // byte address
	typedef logic [31-`TAG_LSB:0] tagT;                        // 25 bits
	typedef logic [`TAG_LSB-`INDEX_LSB-1:0] indexT;            // set number
	typedef logic [`INDEX_LSB-`WORD_LSB-1:0] wordSelT;         // word in line
	typedef logic [$clog2(`CACHE_WAYS)-1:0] wayT;              // way number
	typedef logic [`CACHE_WAYS-1:0] wayMaskT;                  // one bit per way
	typedef logic [`CACHE_WAYS-2:0] lruT;                      // tree bits of one set

	// controller FSM states
	typedef enum logic [3:0] {
		Reset,
		Invalidate,
		Idle,
		CheckHit,
		WaitCacheRead,
		ReadFill,
		CasDelay1,
		CasDelay2,
		BurstFill,
		EndFill,
		WriteDram
	} cacheStateT;

	// CPU side bus, strobes active low
	typedef struct packed {
		addrT addr;
		wordT writeData;
		logic udsL;
		logic ldsL;
		logic weL;
		logic asL;
		logic dramSelect;                                      // active high decode
	} cpuReqT;

	// request to the DRAM controller
	typedef struct packed {
		addrT addr;
		wordT writeData;
		logic udsL;
		logic ldsL;
		logic weL;
		logic asL;
		logic selectL;
	} dramReqT;

	// DRAM side response, CAS and RAS are observed only
	typedef struct packed {
		wordT readData;
		logic dtackL;
		logic casL;
		logic rasL;
	} dramRspT;

endpackage

`default_nettype wire

// File: hdl/m68kCacheTagStore.sv
`timescale 1ns/1ns
`default_nettype none

`include "m68kCache_cfg.svh"

module m68kCacheTagStore (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire m68kCachePkg::indexT index,       // set being looked up or written
	input wire m68kCachePkg::tagT lookupTag,     // tag field of the CPU address
	input wire m68kCachePkg::wayMaskT writeMask, // ways to update this edge
	input wire m68kCachePkg::tagT writeTag,
	input wire logic writeValid,
	output m68kCachePkg::wayMaskT wayHit         // per way hit, combinational
);

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] validBits;          // way major
	m68kCachePkg::tagT tags [`CACHE_WAYS][`CACHE_SETS];

	// valid bits come up cleared, the controller walks the sets again anyway
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			validBits <= '0;
		end else begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (writeMask[w]) begin
					validBits[w][index] <= writeValid;         // fill sets, write clears
				end
			end
		end
	end

	// tag array, written together with the valid bit
	always_ff @(posedge Clock) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (writeMask[w]) begin
				tags[w][index] <= writeTag;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////////////////////

	// a way hits when its line is valid and holds the same tag
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			wayHit[w] = validBits[w][index] && (tags[w][index] == lookupTag);
		end
	end

endmodule

`default_nettype wire

// File: hdl/m68kCache_cfg.svh
`ifndef M68K_CACHE_CFG_SVH
`define M68K_CACHE_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////////////////////

`define CACHE_WAYS 4     // ways per set
`define CACHE_SETS 8     // sets, one index value each
`define LINE_WORDS 8     // 16 bit words in one line

////////////////////////////////////////////////////////////////////////////
// byte address split
////////////////////////////////////////////////////////////////////////////

// tag is addr[31:TAG_LSB], index sits below it, word select below that
`define TAG_LSB 7
`define INDEX_LSB 4
`define WORD_LSB 1       // bit 0 is the byte lane, handled by the strobes

// words moved by one DRAM burst, a full line
`define BURST_LEN 8

`endif

// File: m68kCache.f
+incdir+hdl
hdl/m68kCachePkg.sv
hdl/m68kCacheTagStore.sv
hdl/m68kCacheDataStore.sv
hdl/m68kCacheLruStore.sv
hdl/m68kCacheController.sv
hdl/m68kCache.sv
dv/tbClock.sv
dv/m68kCache_chk.sv
dv/m68kCacheTb.sv
